// File: all.f
+incdir+verification
src/apb_slave_pkg.sv
src/apb_access_check.sv
src/apb_access_fsm.sv
src/apb_byte_mem.sv
src/apb_prot_slave.sv
verification/tb_apb_prot_slave.sv

// File: Bender.yml
package:
  name: apb_prot_slave

sources:
  - files:
      - src/apb_slave_pkg.sv
      - src/apb_access_check.sv
      - src/apb_access_fsm.sv
      - src/apb_byte_mem.sv
      - src/apb_prot_slave.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_apb_prot_slave.sv

// File: verification/tb_apb_tasks.svh
// APB master tasks, value compare helpers, reference memory model
// and the random transfer generator, included in the testbench top
`ifndef TB_APB_TASKS_SVH
`define TB_APB_TASKS_SVH

// xor of the three lower bytes
function automatic byte_t lower_xor(input word_t w);
  return w[7:0] ^ w[15:8] ^ w[23:16];
endfunction

// lower bytes plus a correct top byte
function automatic word_t good_word(input logic [23:0] low);
  return {low[7:0] ^ low[15:8] ^ low[23:16], low};
endfunction

// error rules, 32-byte regions picked by pprot
function automatic logic predict_error(input logic wr, input addr_t a, input prot_t p,
                                       input word_t d, input strb_t s);
  addr_t base;
  base = {a[7:2], 2'b00};
  if (base[7:5] != p) begin
    return 1'b1;
  end
  if (wr) begin
    return d[31:24] != lower_xor(d);
  end
  return s != '0;
endfunction

// read word from the model, checksum rebuilt
function automatic word_t expected_read(input addr_t a);
  addr_t base;
  word_t w;
  base = {a[7:2], 2'b00};
  w = {8'h00, ref_mem[base + 8'd2], ref_mem[base + 8'd1], ref_mem[base]};
  return {lower_xor(w), w[23:0]};
endfunction

// strobed lanes plus the top lane
task automatic model_write(input addr_t a, input word_t d, input strb_t s);
  addr_t base;
  base = {a[7:2], 2'b00};
  for (int lane = 0; lane < 3; lane++) begin
    if (s[lane]) begin
      ref_mem[base + addr_t'(lane)] = d[8*lane +: 8];
    end
  end
  ref_mem[base + 8'd3] = d[31:24];
endtask

task automatic compare_word(input string what, input word_t got, input word_t exp);
  checks++;
  assert (got === exp) else begin
    errors++;
    $display("FAIL @%0t: %s got %08h expected %08h", $time, what, got, exp);
  end
endtask

task automatic compare_bit(input string what, input logic got, input logic exp);
  checks++;
  assert (got === exp) else begin
    errors++;
    $display("FAIL @%0t: %s got %b expected %b", $time, what, got, exp);
  end
endtask

// one transfer, entered and left 2 ns after a rising edge
// keep_sel leaves psel high for a back-to-back setup
task automatic do_transfer(input logic wr, input addr_t a, input prot_t p,
                           input word_t d, input strb_t s, input logic keep_sel,
                           output word_t rd, output logic err);
  int wait_cycles;
  psel    = 1'b1;
  penable = 1'b0;
  pwrite  = wr;
  paddr   = a;
  pprot   = p;
  pwdata  = d;
  pstrb   = s;
  @(posedge PCLK);
  #2;
  penable = 1'b1;
  wait_cycles = 0;
  // response sampled 1 ns after the edge
  do begin
    @(posedge PCLK);
    #1;
    wait_cycles++;
  end while (!pready);
  checks++;
  assert (wait_cycles == 1) else begin
    errors++;
    $display("FAIL @%0t: pready after %0d cycles, expected 1", $time, wait_cycles);
  end
  rd  = prdata;
  err = pslverr;
  // hold until the master edge that samples pready
  @(posedge PCLK);
  #2;
  penable = 1'b0;
  if (!keep_sel) begin
    psel = 1'b0;
    @(posedge PCLK);
    #2;
  end
endtask

task automatic apb_write(input addr_t a, input prot_t p, input word_t d,
                         input strb_t s, input logic keep_sel);
  logic  exp_err;
  logic  err;
  word_t rd;
  exp_err = predict_error(1'b1, a, p, d, s);
  do_transfer(1'b1, a, p, d, s, keep_sel, rd, err);
  compare_bit("write pslverr", err, exp_err);
  compare_word("write prdata", rd, '0);
  if (!exp_err) begin
    model_write(a, d, s);
  end
endtask

task automatic apb_read(input addr_t a, input prot_t p, input strb_t s,
                        input logic keep_sel);
  logic  exp_err;
  logic  err;
  word_t rd;
  word_t exp;
  exp_err = predict_error(1'b0, a, p, '0, s);
  exp = exp_err ? '0 : expected_read(a);
  do_transfer(1'b0, a, p, $random(seed), s, keep_sel, rd, err);
  compare_bit("read pslverr", err, exp_err);
  compare_word("read prdata", rd, exp);
endtask

// random transfers, about a quarter made invalid
task automatic run_random_mix(input int count);
  logic [31:0] r;
  logic [31:0] v;
  logic        wr;
  logic        keep;
  logic        bad;
  prot_t       p;
  addr_t       a;
  word_t       d;
  strb_t       s;
  for (int n = 0; n < count; n++) begin
    r    = $random(seed);
    v    = $random(seed);
    wr   = r[0];
    p    = r[3:1];
    a    = {p, r[8:4]};
    s    = r[12:9];
    keep = r[13] && (n != count - 1);
    bad  = (r[15:14] == 2'b00);
    if (wr) begin
      d = good_word(v[23:0]);
      if (bad && r[16]) begin
        // corrupt the top byte
        d[31:24] = d[31:24] ^ {v[30:24], 1'b1};
      end else if (bad) begin
        // wrong region
        p = p ^ {r[18:17], 1'b1};
      end
      apb_write(a, p, d, s, keep);
    end else begin
      if (bad && r[16]) begin
        s = s | 4'h1;
      end else if (bad) begin
        p = p ^ {r[18:17], 1'b1};
        s = '0;
      end else begin
        s = '0;
      end
      apb_read(a, p, s, keep);
    end
  end
endtask

`endif

// File: verification/tb_apb_prot_slave.sv
// testbench top for the APB protected memory slave
// clock, reset, DUT, protocol assertions, directed and random tests, timeout
`timescale 1ns/1ps
`default_nettype none

module tb_apb_prot_slave import apb_slave_pkg::*; ();

  // run limits sized for about 300 transfers of up to 6 cycles plus reset and margin
  localparam int NUM_RANDOM     = 250;
  localparam int TIMEOUT_CYCLES = 2000;
  localparam int RESET_CYCLES   = 16;

  // dut pins
  logic  PCLK;
  logic  PRESETn;
  logic  psel;
  logic  penable;
  logic  pwrite;
  addr_t paddr;
  prot_t pprot;
  word_t pwdata;
  strb_t pstrb;
  logic  pready;
  logic  pslverr;
  word_t prdata;

  // bookkeeping
  int     checks;
  int     errors;
  int     cycle_count;
  integer seed;

  // reference memory with one byte per address
  byte_t ref_mem [0:MEM_DEPTH-1];

  `include "tb_apb_tasks.svh"

  apb_prot_slave i_dut (
    .PCLK    (PCLK),
    .PRESETn (PRESETn),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pprot   (pprot),
    .pwdata  (pwdata),
    .pstrb   (pstrb),
    .pready  (pready),
    .pslverr (pslverr),
    .prdata  (prdata)
  );

  // 40 ns clock
  initial begin
    PCLK = 1'b0;
    forever #20 PCLK = ~PCLK;
  end

  // pready follows the first sampled access cycle
  a_pready_rise: assert property (@(posedge PCLK) disable iff (!PRESETn)
    (psel && penable && !pready) |=> pready)
  else begin
    errors++;
    $display("FAIL @%0t: pready missing one cycle after penable", $time);
  end

  // one-cycle pready pulse
  a_pready_pulse: assert property (@(posedge PCLK) disable iff (!PRESETn)
    pready |=> !pready)
  else begin
    errors++;
    $display("FAIL @%0t: pready held longer than one cycle", $time);
  end

  // pslverr only together with pready
  a_err_with_ready: assert property (@(posedge PCLK) disable iff (!PRESETn)
    pslverr |-> pready)
  else begin
    errors++;
    $display("FAIL @%0t: pslverr high without pready", $time);
  end

  // prdata zero outside the response cycle
  a_rdata_idle: assert property (@(posedge PCLK) disable iff (!PRESETn)
    !pready |-> (prdata == '0))
  else begin
    errors++;
    $display("FAIL @%0t: prdata %08h outside response cycle", $time, prdata);
  end

  // writes and errored transfers return zero
  a_rdata_zero: assert property (@(posedge PCLK) disable iff (!PRESETn)
    (pready && (pwrite || pslverr)) |-> (prdata == '0))
  else begin
    errors++;
    $display("FAIL @%0t: prdata %08h on write or error", $time, prdata);
  end

  // watchdog
  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge PCLK);
      cycle_count++;
    end
    $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("=== FAIL ===");
    $finish;
  end

  // test sequence
  initial begin
    PRESETn = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pprot   = '0;
    pwdata  = '0;
    pstrb   = '0;
    checks  = 0;
    errors  = 0;
    seed    = 32'h2cd266e9;
    for (int i = 0; i < MEM_DEPTH; i++) begin
      ref_mem[i] = '0;
    end

    repeat (RESET_CYCLES) @(posedge PCLK);
    #2;
    PRESETn = 1'b1;

    // reset values
    compare_bit("pready after reset", pready, 1'b0);
    compare_bit("pslverr after reset", pslverr, 1'b0);
    compare_word("prdata after reset", prdata, '0);
    @(posedge PCLK);
    #2;

    // untouched memory reads zero
    apb_read(8'h04, 3'd0, 4'h0, 1'b0);

    // round trips where unaligned addresses hit the aligned word
    apb_write(8'h08, 3'd0, good_word(24'h123456), 4'hF, 1'b0);
    apb_read(8'h08, 3'd0, 4'h0, 1'b0);
    apb_write(8'hA7, 3'd5, good_word(24'hC0FFEE), 4'hF, 1'b1);
    apb_read(8'hA5, 3'd5, 4'h0, 1'b0);
    apb_write(8'hFD, 3'd7, good_word(24'h00A5A5), 4'hF, 1'b0);
    apb_read(8'hFE, 3'd7, 4'h0, 1'b0);

    // partial strobes keep old lanes while the top byte is always written
    apb_write(8'h20, 3'd1, good_word(24'h112233), 4'hF, 1'b0);
    apb_write(8'h20, 3'd1, good_word(24'hAABBCC), 4'b0101, 1'b0);
    apb_read(8'h20, 3'd1, 4'h0, 1'b0);
    apb_write(8'h20, 3'd1, good_word(24'h778899), 4'b0000, 1'b0);
    apb_read(8'h20, 3'd1, 4'h0, 1'b0);
    apb_write(8'h20, 3'd1, good_word(24'h5A0F3C), 4'b1010, 1'b1);
    apb_read(8'h23, 3'd1, 4'h0, 1'b0);

    // bad checksum leaves memory unchanged
    apb_write(8'h30, 3'd1, good_word(24'h445566), 4'hF, 1'b0);
    apb_write(8'h30, 3'd1, good_word(24'h998877) ^ 32'h0100_0000, 4'hF, 1'b0);
    apb_read(8'h30, 3'd1, 4'h0, 1'b0);
    apb_write(8'h31, 3'd1, good_word(24'h010203) ^ 32'h8000_0000, 4'b0001, 1'b0);
    apb_read(8'h30, 3'd1, 4'h0, 1'b0);

    // region mismatch and read strobes leave the stored word intact
    apb_write(8'h44, 3'd2, good_word(24'hBEEF02), 4'hF, 1'b0);
    apb_write(8'h44, 3'd3, good_word(24'hDEAD01), 4'hF, 1'b0);
    apb_read(8'h44, 3'd3, 4'h0, 1'b0);
    apb_read(8'h44, 3'd0, 4'h0, 1'b0);
    apb_read(8'h44, 3'd2, 4'h1, 1'b0);
    apb_read(8'h44, 3'd2, 4'h8, 1'b1);
    apb_read(8'h44, 3'd2, 4'h0, 1'b0);

    // random mix over all regions
    run_random_mix(NUM_RANDOM);

    repeat (2) @(posedge PCLK);
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src/apb_prot_slave.sv
// top level of the APB protected memory slave,
// connecting the transfer checker, phase FSM and byte memory
`timescale 1ns/1ps
`default_nettype none

module apb_prot_slave import apb_slave_pkg::*; (
  input  logic  PCLK,
  input  logic  PRESETn,
  // apb request
  input  logic  psel,
  input  logic  penable,
  input  logic  pwrite,
  input  addr_t paddr,
  input  prot_t pprot,
  input  word_t pwdata,
  input  strb_t pstrb,
  // apb response
  output logic  pready,
  output logic  pslverr,
  output word_t prdata
);

  // checker to fsm
  logic  access_err;
  // checker to memory
  addr_t word_addr;
  // fsm to memory
  logic  wr_commit;
  logic  rd_commit;

  // combinational rule checks on the live request
  apb_access_check i_check (
    .paddr      (paddr),
    .pprot      (pprot),
    .pwrite     (pwrite),
    .pwdata     (pwdata),
    .pstrb      (pstrb),
    .word_addr  (word_addr),
    .access_err (access_err)
  );

  // protocol sequencing and response flags
  apb_access_fsm i_fsm (
    .PCLK       (PCLK),
    .PRESETn    (PRESETn),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .access_err (access_err),
    .pready     (pready),
    .pslverr    (pslverr),
    .wr_commit  (wr_commit),
    .rd_commit  (rd_commit)
  );

  // storage, written and read on the commit edge
  apb_byte_mem i_mem (
    .PCLK       (PCLK),
    .PRESETn    (PRESETn),
    .word_addr  (word_addr),
    .pwdata     (pwdata),
    .pstrb      (pstrb),
    .wr_commit  (wr_commit),
    .rd_commit  (rd_commit),
    .prdata     (prdata)
  );

endmodule

`default_nettype wire

// File: src/apb_byte_mem.sv
// byte-wide 256 entry memory with strobed word writes,
// checksum lane always written, registered read word with fresh checksum
`timescale 1ns/1ps
`default_nettype none

module apb_byte_mem import apb_slave_pkg::*; (
  input  logic  PCLK,
  input  logic  PRESETn,
  input  addr_t word_addr,
  input  word_t pwdata,
  input  strb_t pstrb,
  input  logic  wr_commit,
  input  logic  rd_commit,
  output word_t prdata
);

  // storage, one byte per address
  byte_t mem [0:MEM_DEPTH-1];

  // lower lanes fetched from the array, top lane zero
  word_t rd_lanes;
  // lower lanes plus recomputed checksum
  word_t rd_word;

  // write port
  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      for (int i = 0; i < MEM_DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (wr_commit) begin
      for (int lane = 0; lane < STRB_WIDTH; lane++) begin
        // checksum lane goes in regardless of its strobe
        if (pstrb[lane] || lane == CRC_LANE) begin
          mem[word_addr + addr_t'(lane)] <= pwdata[8*lane +: 8];
        end
      end
    end
  end

  // gather lower bytes of the addressed word
  // word_addr is aligned so the lane offset never wraps
  always_comb begin
    rd_lanes = '0;
    for (int lane = 0; lane < CRC_LANE; lane++) begin
      rd_lanes[8*lane +: 8] = mem[word_addr + addr_t'(lane)];
    end
  end

  // stored checksum byte is not returned, rebuilt from the data
  assign rd_word = {word_checksum(rd_lanes), rd_lanes[8*CRC_LANE-1:0]};

  // read data register
  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      prdata <= '0;
    end else if (rd_commit) begin
      prdata <= rd_word;
    end else begin
      // zero outside the read response cycle
      prdata <= '0;
    end
  end

endmodule

`default_nettype wire

// File: src/apb_access_fsm.sv
// APB phase FSM: idle, setup and access states,
// registered pready/pslverr and the write/read commit pulses
`timescale 1ns/1ps
`default_nettype none

module apb_access_fsm import apb_slave_pkg::*; (
  input  logic PCLK,
  input  logic PRESETn,
  input  logic psel,
  input  logic penable,
  input  logic pwrite,
  input  logic access_err,
  output logic pready,
  output logic pslverr,
  output logic wr_commit,
  output logic rd_commit
);

  apb_state_t state_q;
  apb_state_t state_nxt;

  // first cycle of the access phase as seen by the slave
  logic access_entry;

  assign access_entry = (state_q == st_setup) && psel && penable;

  // commits only for error-free transfers
  // both pulses live for the single access-entry edge
  assign wr_commit = access_entry && pwrite && !access_err;
  assign rd_commit = access_entry && !pwrite && !access_err;

  // next state
  always_comb begin
    state_nxt = state_q;
    case (state_q)
      st_idle: begin
        if (psel) begin
          state_nxt = st_setup;
        end
      end
      st_setup: begin
        // wait here while master holds setup phase
        if (!psel) begin
          state_nxt = st_idle;
        end else if (penable) begin
          state_nxt = st_access;
        end
      end
      st_access: begin
        // one access cycle only, pready is never held off
        if (psel) begin
          state_nxt = st_setup;
        end else begin
          state_nxt = st_idle;
        end
      end
      default: begin
        state_nxt = st_idle;
      end
    endcase
  end

  // state and response registers
  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      state_q <= st_idle;
      pready  <= 1'b0;
      pslverr <= 1'b0;
    end else begin
      state_q <= state_nxt;
      // high for exactly the cycle after penable is sampled
      pready  <= access_entry;
      // error flag qualified by the same edge
      pslverr <= access_entry && access_err;
    end
  end

endmodule

`default_nettype wire

// File: src/apb_access_check.sv
// transfer checker: word alignment, pprot region match,
// write checksum and read strobe rules folded into one error flag
`timescale 1ns/1ps
`default_nettype none

module apb_access_check import apb_slave_pkg::*; (
  input  addr_t paddr,
  input  prot_t pprot,
  input  logic  pwrite,
  input  word_t pwdata,
  input  strb_t pstrb,
  output addr_t word_addr,
  output logic  access_err
);

  // region the aligned address falls into
  prot_t region;

  // individual violations
  logic  region_err;
  logic  crc_err;
  logic  strb_err;

  // top byte of the write data as sent
  byte_t wr_crc;

  // clear the byte offset bits
  assign word_addr = paddr & ~addr_t'(STRB_WIDTH - 1);

  // 32-byte regions, so the upper address bits pick the region
  assign region = prot_t'(word_addr / REGION_SIZE);

  // pprot must select the region being touched
  assign region_err = (region != pprot);

  assign wr_crc = pwdata[8*CRC_LANE +: 8];

  // writes carry xor of the lower bytes in the top lane
  // all lower bytes count, whatever the strobes
  assign crc_err = pwrite && (wr_crc != word_checksum(pwdata));

  // reads must come with every strobe low
  assign strb_err = !pwrite && (pstrb != '0);

  // any violation kills the transfer
  assign access_err = region_err || crc_err || strb_err;

endmodule

`default_nettype wire

// File: src/apb_slave_pkg.sv
// shared widths, region geometry, bus types, FSM state enum
// and the word checksum function for the APB protected memory slave
`default_nettype none

package apb_slave_pkg;

  // bus geometry
  localparam int DATA_WIDTH  = 32;
  localparam int ADDR_WIDTH  = 8;
  localparam int STRB_WIDTH  = DATA_WIDTH / 8;

  // memory and protection regions
  localparam int MEM_DEPTH   = 256;
  localparam int REGION_SIZE = 32;

  // top byte lane carries the checksum
  localparam int CRC_LANE    = 3;

  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [DATA_WIDTH-1:0] word_t;
  typedef logic [STRB_WIDTH-1:0] strb_t;
  typedef logic [7:0]            byte_t;
  // pprot code, doubles as region number
  typedef logic [2:0]            prot_t;

  typedef enum logic [1:0] {
    st_idle,
    st_setup,
    st_access
  } apb_state_t;

  // xor of every lane below the checksum lane
  function automatic byte_t word_checksum(input word_t w);
    byte_t c;
    c = '0;
    for (int lane = 0; lane < CRC_LANE; lane++) begin
      c ^= w[8*lane +: 8];
    end
    return c;
  endfunction

endpackage

`default_nettype wire
